/* floo_axi_chimney.f */
hdl/chimney_axi_pkg.sv
hdl/chimney_noc_pkg.sv
hdl/chimney_ax_if.sv
hdl/chimney_route_decoder.sv
hdl/chimney_spill_reg.sv
hdl/chimney_req_packer.sv
hdl/chimney_ctrl.sv
hdl/chimney_rsp_unpacker.sv
hdl/floo_axi_chimney.sv
tb/chimney_checker.sv
tb/tb_floo_axi_chimney.sv

/* hdl/chimney_ax_if.sv */
// One AXI address channel (AW or AR) inside the network interface
// Valid/ready handshake; id, addr and len stay stable while valid is high
`timescale 1ns/10ps

interface chimney_ax_if;
  import chimney_axi_pkg::*;

  logic      valid;
  logic      ready;
  axi_id_t   id;
  axi_addr_t addr;
  axi_len_t  len;

  modport src  (output valid, id, addr, len, input ready);
  modport ctrl (input valid, output ready);
  modport data (input id, addr, len);

endinterface

/* hdl/chimney_axi_pkg.sv */
// AXI4 subset seen by the manager-side network interface
// Only id, addr and len travel on AW/AR; no strobes, user or atomics
package chimney_axi_pkg;

  localparam int unsigned AxiIdWidth   = 4;
  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 32;
  localparam int unsigned AxiLenWidth  = 8;

  typedef logic [AxiIdWidth-1:0]   axi_id_t;
  typedef logic [AxiAddrWidth-1:0] axi_addr_t;
  typedef logic [AxiDataWidth-1:0] axi_data_t;
  typedef logic [AxiLenWidth-1:0]  axi_len_t;
  typedef logic [1:0]              axi_resp_t;

  // Standard AXI response codes
  localparam axi_resp_t RespOkay   = 2'b00;
  localparam axi_resp_t RespExOkay = 2'b01;
  localparam axi_resp_t RespSlvErr = 2'b10;
  localparam axi_resp_t RespDecErr = 2'b11;

  // AW and AR share one layout, 44 bits
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } axi_ax_t;

  // Response payloads as they sit right-aligned in a flit
  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

endpackage

/* hdl/chimney_ctrl.sv */
// Request link control with AW/W sequencing, wormhole lock and AR round robin
// Grant is combinational; a stalled flit keeps its grant until it is taken
// Relies on requesters holding valid until their handshake
`timescale 1ns/10ps

module chimney_ctrl (
  input  logic       clk_i,
  input  logic       arst_n_i,
  chimney_ax_if.ctrl aw_ch,
  chimney_ax_if.ctrl ar_ch,
  input  logic       w_valid_i,
  input  logic       w_last_i,
  input  logic       req_ready_i,
  output logic       w_ready_o,
  output logic       req_valid_o,
  output logic       sel_aw_o,
  output logic       sel_w_o,
  output logic       w_dst_load_o
);

  typedef enum logic {SelAw, SelW} aw_w_sel_e;

  aw_w_sel_e sel_q;
  logic      lock_q;
  logic      hold_q;
  logic      hold_ar_q;
  logic      rr_ar_q;
  logic      wr_req, ar_req;
  logic      gnt_wr, gnt_ar;
  logic      wr_hs, ar_hs;
  logic      wr_last;

  // Write route is AW first, then the W beats of that burst
  assign wr_req  = (sel_q == SelAw) ? aw_ch.valid : w_valid_i;
  assign ar_req  = ar_ch.valid;
  assign wr_last = (sel_q == SelW) && w_last_i;

  ////////////////////
  // Grant
  ////////////////////

  always_comb begin
    gnt_wr = 1'b0;
    gnt_ar = 1'b0;
    if (lock_q) begin
      gnt_wr = wr_req;
    end else if (hold_q) begin
      gnt_ar = hold_ar_q && ar_req;
      gnt_wr = !hold_ar_q && wr_req;
    end else if (wr_req && ar_req) begin
      gnt_ar = rr_ar_q;
      gnt_wr = !rr_ar_q;
    end else begin
      gnt_ar = ar_req;
      gnt_wr = wr_req;
    end
  end

  assign wr_hs = gnt_wr && req_ready_i;
  assign ar_hs = gnt_ar && req_ready_i;

  assign req_valid_o  = gnt_wr || gnt_ar;
  assign sel_aw_o     = gnt_wr && (sel_q == SelAw);
  assign sel_w_o      = gnt_wr && (sel_q == SelW);
  assign aw_ch.ready  = wr_hs && (sel_q == SelAw);
  assign w_ready_o    = wr_hs && (sel_q == SelW);
  assign ar_ch.ready  = ar_hs;
  assign w_dst_load_o = aw_ch.valid && aw_ch.ready;

  ////////////////////
  // State
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q     <= SelAw;
      lock_q    <= 1'b0;
      hold_q    <= 1'b0;
      hold_ar_q <= 1'b0;
      rr_ar_q   <= 1'b0;
    end else begin
      if (aw_ch.valid && aw_ch.ready) begin
        sel_q <= SelW;
      end else if (w_ready_o && w_valid_i && w_last_i) begin
        sel_q <= SelAw;
      end
      // The worm stays open until a flit with last set leaves
      if (wr_hs) lock_q <= !wr_last;
      hold_q    <= req_valid_o && !req_ready_i;
      hold_ar_q <= gnt_ar;
      // After a read the write route gets priority and after a write the AR
      if (ar_hs) begin
        rr_ar_q <= 1'b0;
      end else if (wr_hs && wr_last) begin
        rr_ar_q <= 1'b1;
      end
    end
  end

  a_no_w_in_aw: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    w_ready_o |-> lock_q)
    else $error("W accepted before its AW flit");

  a_no_ar_locked: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_ch.ready |-> (sel_q == SelAw))
    else $error("AR granted inside a write burst");

  a_grant_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(gnt_ar))
    else $error("Request link changed owner while stalled");

endmodule

/* hdl/chimney_noc_pkg.sv */
// Flit format and address map for the chimney NoC links
// Rule table is fixed at elaboration; ranges are half open [base, end)
// Addresses that match no rule go to the error tile
package chimney_noc_pkg;

  typedef logic [3:0] tile_id_t;

  typedef enum logic [2:0] {
    AxiAw = 3'd0,
    AxiW  = 3'd1,
    AxiAr = 3'd2,
    AxiB  = 3'd3,
    AxiR  = 3'd4
  } axi_ch_e;

  typedef struct packed {
    tile_id_t dst_id;
    tile_id_t src_id;
    axi_ch_e  axi_ch;
    logic     last;
  } flit_hdr_t;

  // Widest payload is an AX beat
  localparam int unsigned PayloadWidth = $bits(chimney_axi_pkg::axi_ax_t);

  typedef struct packed {
    flit_hdr_t                hdr;
    logic [PayloadWidth-1:0]  payload;
  } flit_t;

  ////////////////////
  // Address map
  ////////////////////

  localparam int unsigned NumRules = 4;

  localparam chimney_axi_pkg::axi_addr_t RuleBase [NumRules] =
    '{32'h0000_0000, 32'h0000_1000, 32'h0000_2000, 32'h0000_3000};
  localparam chimney_axi_pkg::axi_addr_t RuleEnd [NumRules] =
    '{32'h0000_1000, 32'h0000_2000, 32'h0000_3000, 32'h0000_4000};
  localparam tile_id_t RuleDst [NumRules] = '{4'd1, 4'd2, 4'd3, 4'd4};

  localparam tile_id_t ErrTileId = 4'd15;

endpackage

/* hdl/chimney_req_packer.sv */
// Builds AW, W and AR request flits; flit_o is picked by the ctrl strobes
// W flits reuse the destination latched at the AW flit handshake
`timescale 1ns/10ps

module chimney_req_packer (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  chimney_ax_if.data                 aw_ch,
  chimney_ax_if.data                 ar_ch,
  input  chimney_axi_pkg::axi_data_t w_data_i,
  input  logic                       w_last_i,
  input  chimney_noc_pkg::tile_id_t  id_i,
  input  logic                       sel_aw_i,
  input  logic                       sel_w_i,
  input  logic                       w_dst_load_i,
  output chimney_noc_pkg::flit_t     flit_o
);
  import chimney_axi_pkg::*;
  import chimney_noc_pkg::*;

  tile_id_t aw_dst;
  tile_id_t ar_dst;
  tile_id_t w_dst_q;
  axi_ax_t  aw_ax;
  axi_ax_t  ar_ax;
  flit_t    aw_flit;
  flit_t    w_flit;
  flit_t    ar_flit;

  chimney_route_decoder i_aw_decoder (
    .addr_i ( aw_ch.addr ),
    .dst_o  ( aw_dst     ),
    .miss_o (            )
  );

  chimney_route_decoder i_ar_decoder (
    .addr_i ( ar_ch.addr ),
    .dst_o  ( ar_dst     ),
    .miss_o (            )
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      w_dst_q <= ErrTileId;
    end else if (w_dst_load_i) begin
      w_dst_q <= aw_dst;
    end
  end

  assign aw_ax = '{id: aw_ch.id, addr: aw_ch.addr, len: aw_ch.len};
  assign ar_ax = '{id: ar_ch.id, addr: ar_ch.addr, len: ar_ch.len};

  // AW opens a worm, AR is a single flit
  assign aw_flit = '{hdr: '{dst_id: aw_dst, src_id: id_i, axi_ch: AxiAw, last: 1'b0},
                     payload: aw_ax};
  assign w_flit  = '{hdr: '{dst_id: w_dst_q, src_id: id_i, axi_ch: AxiW, last: w_last_i},
                     payload: PayloadWidth'(w_data_i)};
  assign ar_flit = '{hdr: '{dst_id: ar_dst, src_id: id_i, axi_ch: AxiAr, last: 1'b1},
                     payload: ar_ax};

  assign flit_o = sel_aw_i ? aw_flit : (sel_w_i ? w_flit : ar_flit);

endmodule

/* hdl/chimney_route_decoder.sv */
// Address to destination tile lookup, purely combinational
// Lowest matching rule wins; a miss routes to the error tile
`timescale 1ns/10ps

module chimney_route_decoder (
  input  chimney_axi_pkg::axi_addr_t addr_i,
  output chimney_noc_pkg::tile_id_t  dst_o,
  output logic                       miss_o
);
  import chimney_noc_pkg::*;

  // Walk downwards so the lowest index hit is the last one written
  always_comb begin
    dst_o  = ErrTileId;
    miss_o = 1'b1;
    for (int k = NumRules - 1; k >= 0; k--) begin
      if (addr_i >= RuleBase[k] && addr_i < RuleEnd[k]) begin
        dst_o  = RuleDst[k];
        miss_o = 1'b0;
      end
    end
  end

  // Map sanity, checked once at start of simulation
  initial begin
    for (int i = 0; i < NumRules; i++) begin
      assert (RuleBase[i] < RuleEnd[i])
        else $error("Address rule %0d is empty", i);
      for (int j = i + 1; j < NumRules; j++) begin
        assert (RuleEnd[i] <= RuleBase[j] || RuleEnd[j] <= RuleBase[i])
          else $error("Address rules %0d and %0d overlap", i, j);
      end
    end
  end

endmodule

/* hdl/chimney_rsp_unpacker.sv */
// Splits response flits into AXI B and R beats, combinational
// Flits with a request tag are dropped so the link cannot hang
`timescale 1ns/10ps

module chimney_rsp_unpacker (
  input  logic                       valid_i,
  input  chimney_noc_pkg::flit_t     flit_i,
  input  logic                       b_ready_i,
  input  logic                       r_ready_i,
  output logic                       ready_o,
  output logic                       b_valid_o,
  output chimney_axi_pkg::axi_id_t   b_id_o,
  output chimney_axi_pkg::axi_resp_t b_resp_o,
  output logic                       r_valid_o,
  output chimney_axi_pkg::axi_id_t   r_id_o,
  output chimney_axi_pkg::axi_data_t r_data_o,
  output chimney_axi_pkg::axi_resp_t r_resp_o,
  output logic                       r_last_o
);
  import chimney_axi_pkg::*;
  import chimney_noc_pkg::*;

  axi_b_t b_pl;
  axi_r_t r_pl;
  logic   is_b;
  logic   is_r;

  assign is_b = (flit_i.hdr.axi_ch == AxiB);
  assign is_r = (flit_i.hdr.axi_ch == AxiR);
  assign b_pl = axi_b_t'(flit_i.payload[$bits(axi_b_t)-1:0]);
  assign r_pl = axi_r_t'(flit_i.payload[$bits(axi_r_t)-1:0]);

  assign b_valid_o = valid_i && is_b;
  assign b_id_o    = b_pl.id;
  assign b_resp_o  = b_pl.resp;
  assign r_valid_o = valid_i && is_r;
  assign r_id_o    = r_pl.id;
  assign r_data_o  = r_pl.data;
  assign r_resp_o  = r_pl.resp;
  assign r_last_o  = r_pl.last;

  assign ready_o = is_b ? b_ready_i : (is_r ? r_ready_i : 1'b1);

  // The far side must only send B and R on this link
  always_comb begin
    if (valid_i) begin
      assert (is_b || is_r)
        else $error("Request tag %0d on response link", flit_i.hdr.axi_ch);
    end
  end

endmodule

/* hdl/chimney_spill_reg.sv */
// Two-slot spill stage, cuts valid, ready and data paths
// Ready comes from a flop and is low while reset is applied
// Full throughput under steady drain, one cycle latency when empty
`timescale 1ns/10ps

module chimney_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     a_full_q, a_full_d;
  logic     b_full_q, b_full_d;
  logic     ready_q;
  logic     a_fill, a_drain;
  logic     b_fill, b_drain;
  payload_t a_data_q;
  payload_t b_data_q;

  // Slot A takes new items, slot B catches A when the sink stalls
  assign a_fill   = valid_i && ready_q;
  assign a_drain  = a_full_q && !b_full_q;
  assign b_fill   = a_drain && !ready_i;
  assign b_drain  = b_full_q && ready_i;
  assign a_full_d = a_fill || (a_full_q && !a_drain);
  assign b_full_d = b_fill || (b_full_q && !b_drain);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      ready_q  <= !(a_full_d && b_full_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // B always holds the older item
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = ready_q;

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("Spill output changed while stalled");

endmodule

/* hdl/floo_axi_chimney.sv */
// Manager-side AXI network interface on one request and one response link
// AW, AR and the response input pass through fixed spill stages
// W beats go straight to the link once their AW flit has left
// Single AXI ID space, no reordering and no atomics
`timescale 1ns/10ps

module floo_axi_chimney (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // AXI manager side
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  chimney_axi_pkg::axi_id_t   aw_id_i,
  input  chimney_axi_pkg::axi_addr_t aw_addr_i,
  input  chimney_axi_pkg::axi_len_t  aw_len_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  input  chimney_axi_pkg::axi_data_t w_data_i,
  input  logic                       w_last_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  chimney_axi_pkg::axi_id_t   ar_id_i,
  input  chimney_axi_pkg::axi_addr_t ar_addr_i,
  input  chimney_axi_pkg::axi_len_t  ar_len_i,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  output chimney_axi_pkg::axi_id_t   b_id_o,
  output chimney_axi_pkg::axi_resp_t b_resp_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output chimney_axi_pkg::axi_id_t   r_id_o,
  output chimney_axi_pkg::axi_data_t r_data_o,
  output chimney_axi_pkg::axi_resp_t r_resp_o,
  output logic                       r_last_o,
  // Tile coordinate and NoC links
  input  chimney_noc_pkg::tile_id_t  id_i,
  output logic                       req_valid_o,
  input  logic                       req_ready_i,
  output chimney_noc_pkg::flit_t     req_flit_o,
  input  logic                       rsp_valid_i,
  output logic                       rsp_ready_o,
  input  chimney_noc_pkg::flit_t     rsp_flit_i
);
  import chimney_axi_pkg::*;
  import chimney_noc_pkg::*;

  axi_ax_t aw_in, aw_out;
  axi_ax_t ar_in, ar_out;
  flit_t   rsp_flit;
  logic    rsp_valid;
  logic    rsp_ready;
  logic    sel_aw, sel_w, w_dst_load;

  chimney_ax_if aw_ch ();
  chimney_ax_if ar_ch ();

  ////////////////////
  // Spill stages
  ////////////////////

  assign aw_in = '{id: aw_id_i, addr: aw_addr_i, len: aw_len_i};
  assign ar_in = '{id: ar_id_i, addr: ar_addr_i, len: ar_len_i};

  chimney_spill_reg #(.payload_t(axi_ax_t)) i_aw_spill (
    .clk_i, .arst_n_i,
    .valid_i ( aw_valid_i  ),
    .data_i  ( aw_in       ),
    .ready_o ( aw_ready_o  ),
    .valid_o ( aw_ch.valid ),
    .data_o  ( aw_out      ),
    .ready_i ( aw_ch.ready )
  );

  chimney_spill_reg #(.payload_t(axi_ax_t)) i_ar_spill (
    .clk_i, .arst_n_i,
    .valid_i ( ar_valid_i  ),
    .data_i  ( ar_in       ),
    .ready_o ( ar_ready_o  ),
    .valid_o ( ar_ch.valid ),
    .data_o  ( ar_out      ),
    .ready_i ( ar_ch.ready )
  );

  assign aw_ch.id   = aw_out.id;
  assign aw_ch.addr = aw_out.addr;
  assign aw_ch.len  = aw_out.len;
  assign ar_ch.id   = ar_out.id;
  assign ar_ch.addr = ar_out.addr;
  assign ar_ch.len  = ar_out.len;

  chimney_spill_reg #(.payload_t(flit_t)) i_rsp_spill (
    .clk_i, .arst_n_i,
    .valid_i ( rsp_valid_i ),
    .data_i  ( rsp_flit_i  ),
    .ready_o ( rsp_ready_o ),
    .valid_o ( rsp_valid   ),
    .data_o  ( rsp_flit    ),
    .ready_i ( rsp_ready   )
  );

  ////////////////////
  // Request path
  ////////////////////

  chimney_ctrl i_ctrl (
    .clk_i, .arst_n_i,
    .aw_ch        ( aw_ch       ),
    .ar_ch        ( ar_ch       ),
    .w_valid_i    ( w_valid_i   ),
    .w_last_i     ( w_last_i    ),
    .req_ready_i  ( req_ready_i ),
    .w_ready_o    ( w_ready_o   ),
    .req_valid_o  ( req_valid_o ),
    .sel_aw_o     ( sel_aw      ),
    .sel_w_o      ( sel_w       ),
    .w_dst_load_o ( w_dst_load  )
  );

  chimney_req_packer i_packer (
    .clk_i, .arst_n_i,
    .aw_ch        ( aw_ch      ),
    .ar_ch        ( ar_ch      ),
    .w_data_i     ( w_data_i   ),
    .w_last_i     ( w_last_i   ),
    .id_i         ( id_i       ),
    .sel_aw_i     ( sel_aw     ),
    .sel_w_i      ( sel_w      ),
    .w_dst_load_i ( w_dst_load ),
    .flit_o       ( req_flit_o )
  );

  // Response path
  chimney_rsp_unpacker i_unpacker (
    .valid_i   ( rsp_valid ),
    .flit_i    ( rsp_flit  ),
    .b_ready_i ( b_ready_i ),
    .r_ready_i ( r_ready_i ),
    .ready_o   ( rsp_ready ),
    .b_valid_o ( b_valid_o ),
    .b_id_o    ( b_id_o    ),
    .b_resp_o  ( b_resp_o  ),
    .r_valid_o ( r_valid_o ),
    .r_id_o    ( r_id_o    ),
    .r_data_o  ( r_data_o  ),
    .r_resp_o  ( r_resp_o  ),
    .r_last_o  ( r_last_o  )
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the chimney testbench with Verilator, run from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary -f floo_axi_chimney.f --top-module tb_floo_axi_chimney -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_floo_axi_chimney > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation run failed"
  exit 1
fi

cat sim.log
if grep -q "^sim passed$" sim.log; then
  exit 0
else
  exit 1
fi

/* tb/chimney_checker.sv */
// Watches the DUT request link and the AXI B/R outputs
// Expected flits and beats are queued by the testbench in arrival order
// Samples 15 ns after the falling edge, when all handshake signals are settled
`timescale 1ns/10ps

module chimney_checker (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       req_valid_i,
  input  logic                       req_ready_i,
  input  chimney_noc_pkg::flit_t     req_flit_i,
  input  logic                       b_valid_i,
  input  logic                       b_ready_i,
  input  chimney_axi_pkg::axi_id_t   b_id_i,
  input  chimney_axi_pkg::axi_resp_t b_resp_i,
  input  logic                       r_valid_i,
  input  logic                       r_ready_i,
  input  chimney_axi_pkg::axi_id_t   r_id_i,
  input  chimney_axi_pkg::axi_data_t r_data_i,
  input  chimney_axi_pkg::axi_resp_t r_resp_i,
  input  logic                       r_last_i
);
  import chimney_axi_pkg::*;
  import chimney_noc_pkg::*;

  string       test_name = "none";
  flit_t       flit_q[$];
  logic [5:0]  b_q[$];
  logic [38:0] r_q[$];
  int          test_errs = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          error_total = 0;

  ////////////////////
  // Testbench hooks
  ////////////////////

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic expect_flit(input flit_t f);
    flit_q.push_back(f);
  endtask

  task automatic expect_b(input logic [5:0] beat);
    b_q.push_back(beat);
  endtask

  task automatic expect_r(input logic [38:0] beat);
    r_q.push_back(beat);
  endtask

  function automatic int pending();
    return flit_q.size() + b_q.size() + r_q.size();
  endfunction

  // Plain failures, no value to compare
  task automatic note_failure(input string msg);
    $display("Error in test %s: %s", test_name, msg);
    test_errs++;
    error_total++;
  endtask

  task automatic end_test();
    if (pending() != 0) begin
      note_failure($sformatf("%0d expected items never showed up", pending()));
    end
    flit_q.delete();
    b_q.delete();
    r_q.delete();
    if (test_errs == 0) begin
      $display("PASS %s", test_name);
      tests_passed++;
    end else begin
      $display("FAIL %s with %0d errors", test_name, test_errs);
      tests_failed++;
    end
  endtask

  task automatic report();
    $display("Tests: %0d passed, %0d failed, %0d errors",
             tests_passed, tests_failed, error_total);
  endtask

  ////////////////////
  // Comparison
  ////////////////////

  task automatic compare(input string what, input logic [55:0] exp, input logic [55:0] act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errs++;
      error_total++;
    end
  endtask

  always @(negedge clk_i) begin
    #15;
    if (arst_n_i) begin
      if (req_valid_i && req_ready_i) begin
        if (flit_q.size() == 0) note_failure("request flit sent that was not expected");
        else compare("request flit", 56'(flit_q.pop_front()), 56'(req_flit_i));
      end
      if (b_valid_i && b_ready_i) begin
        if (b_q.size() == 0) note_failure("B beat arrived that was not expected");
        else compare("B beat", 56'(b_q.pop_front()), 56'({b_id_i, b_resp_i}));
      end
      if (r_valid_i && r_ready_i) begin
        if (r_q.size() == 0) note_failure("R beat arrived that was not expected");
        else compare("R beat", 56'(r_q.pop_front()),
                     56'({r_id_i, r_data_i, r_resp_i, r_last_i}));
      end
    end
  end

endmodule

/* tb/chimney_stimulus.txt */
# Ops in hex: T name, P mode, A|R id addr len, W data last, B id resp, D id data resp last, E
# F dst ch last payload queues an expected request flit; B and D also queue the expected beat
T ar_read
F 2 2 1 30000123400
R 3 00001234 00
E
T aw_burst
F 3 0 0 10000201002
F 3 1 0 A0000001
F 3 1 0 A0000002
F 3 1 1 A0000003
A 1 00002010 02
W A0000001 0
W A0000002 0
W A0000003 1
E
T ar_during_write
F 1 0 0 20000004001
F 1 1 0 B1
F 1 1 1 B2
F 4 2 1 40000300003
A 2 00000040 01
W B1 0
R 4 00003000 03
W B2 1
E
T ar_aw_alternate
F 1 2 1 50000010000
F 3 0 0 70000220000
F 3 1 1 C1
F 2 2 1 60000110000
P 2
R 5 00000100 00
R 6 00001100 00
A 7 00002200 00
P 0
W C1 1
E
T addr_miss
F F 2 1 88000000000
R 8 80000000 00
E
T responses
B 9 0
D 3 DEADBEEF 0 0
D 3 12345678 2 1
B A 3
E
T random_backpressure
F 4 0 0 B00003F0002
F 4 1 0 D1
F 4 1 0 D2
F 4 1 1 D3
F 1 2 1 C00000FFC01
P 1
A B 00003F00 02
W D1 0
W D2 0
W D3 1
R C 00000FFC 01
B B 0
D C 00000011 0 0
D C 00000022 1 1
E
P 0

/* tb/tb_floo_axi_chimney.sv */
// Testbench for the manager-side chimney, driven from tb/chimney_stimulus.txt
// Inputs change on the falling edge; back-pressure is set 1 ns after it
// Tile coordinate of the DUT is fixed at 6
`timescale 1ns/10ps

module tb_floo_axi_chimney;
  import chimney_axi_pkg::*;
  import chimney_noc_pkg::*;

  localparam int       Timeout = 300;
  localparam tile_id_t TileId  = 4'h6;

  logic      clk_i = 1'b0;
  logic      arst_n_i;
  logic      aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, w_last_i;
  logic      ar_valid_i, ar_ready_o, b_valid_o, b_ready_i;
  logic      r_valid_o, r_ready_i, r_last_o;
  axi_id_t   aw_id_i, ar_id_i, b_id_o, r_id_o;
  axi_addr_t aw_addr_i, ar_addr_i;
  axi_len_t  aw_len_i, ar_len_i;
  axi_data_t w_data_i, r_data_o;
  axi_resp_t b_resp_o, r_resp_o;
  logic      req_valid_o, req_ready_i, rsp_valid_i, rsp_ready_o;
  flit_t     req_flit_o, rsp_flit_i;
  logic [1:0]  bp_mode = 2'd0;
  logic [15:0] lfsr = 16'd50;
  logic        aborted = 1'b0;

  always #20 clk_i = ~clk_i;

  floo_axi_chimney UUT (
    .clk_i, .arst_n_i,
    .aw_valid_i, .aw_ready_o, .aw_id_i, .aw_addr_i, .aw_len_i,
    .w_valid_i, .w_ready_o, .w_data_i, .w_last_i,
    .ar_valid_i, .ar_ready_o, .ar_id_i, .ar_addr_i, .ar_len_i,
    .b_valid_o, .b_ready_i, .b_id_o, .b_resp_o,
    .r_valid_o, .r_ready_i, .r_id_o, .r_data_o, .r_resp_o, .r_last_o,
    .id_i (TileId),
    .req_valid_o, .req_ready_i, .req_flit_o,
    .rsp_valid_i, .rsp_ready_o, .rsp_flit_i
  );

  chimney_checker chk (
    .clk_i, .arst_n_i,
    .req_valid_i (req_valid_o), .req_ready_i, .req_flit_i (req_flit_o),
    .b_valid_i (b_valid_o), .b_ready_i, .b_id_i (b_id_o), .b_resp_i (b_resp_o),
    .r_valid_i (r_valid_o), .r_ready_i, .r_id_i (r_id_o), .r_data_i (r_data_o),
    .r_resp_i (r_resp_o), .r_last_i (r_last_o)
  );

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // Mode 0 always ready, 1 random, 2 request link stalled
  always @(negedge clk_i) begin
    #1;
    case (bp_mode)
      2'd1: begin
        lfsr = lfsr_next(lfsr);
        req_ready_i = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b_ready_i = lfsr[0];
        lfsr = lfsr_next(lfsr);
        r_ready_i = lfsr[0];
      end
      2'd2: begin
        req_ready_i = 1'b0;
        b_ready_i   = 1'b1;
        r_ready_i   = 1'b1;
      end
      default: begin
        req_ready_i = 1'b1;
        b_ready_i   = 1'b1;
        r_ready_i   = 1'b1;
      end
    endcase
  end

  function automatic logic ready_of(input int ch);
    case (ch)
      0: return aw_ready_o;
      1: return w_ready_o;
      2: return ar_ready_o;
      default: return rsp_ready_o;
    endcase
  endfunction

  // Called on a falling edge with valid raised; returns on the edge after the transfer
  task automatic handshake(input int ch, input string what);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < Timeout) begin
      #15;
      if (ready_of(ch)) done = 1'b1;
      @(negedge clk_i);
      cycles++;
    end
    if (!done) begin
      chk.note_failure($sformatf("%s handshake never happened", what));
      aborted = 1'b1;
    end
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (chk.pending() != 0 && cycles < Timeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if (chk.pending() != 0) begin
      chk.note_failure("expected flits or beats still outstanding after the wait");
      aborted = 1'b1;
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int          fd;
    int          n;
    string       op;
    string       name;
    string       rest;
    logic [63:0] a, b, c, d;
    flit_t       f;
    arst_n_i    = 1'b0;
    aw_valid_i  = 1'b0;
    aw_id_i     = '0;
    aw_addr_i   = '0;
    aw_len_i    = '0;
    w_valid_i   = 1'b0;
    w_data_i    = '0;
    w_last_i    = 1'b0;
    ar_valid_i  = 1'b0;
    ar_id_i     = '0;
    ar_addr_i   = '0;
    ar_len_i    = '0;
    b_ready_i   = 1'b1;
    r_ready_i   = 1'b1;
    req_ready_i = 1'b1;
    rsp_valid_i = 1'b0;
    rsp_flit_i  = '0;
    repeat (5) @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    fd = $fopen("tb/chimney_stimulus.txt", "r");
    if (fd == 0) begin
      chk.note_failure("stimulus file could not be opened");
      aborted = 1'b1;
    end
    while (!aborted) begin
      n = $fscanf(fd, "%s", op);
      if (n != 1) break;
      if (op == "#") begin
        n = $fgets(rest, fd);
      end else if (op == "T") begin
        n = $fscanf(fd, "%s", name);
        chk.start_test(name);
      end else if (op == "P") begin
        n = $fscanf(fd, "%h", a);
        bp_mode = a[1:0];
      end else if (op == "F") begin
        n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
        f.hdr.dst_id  = a[3:0];
        f.hdr.src_id  = TileId;
        f.hdr.axi_ch  = axi_ch_e'(b[2:0]);
        f.hdr.last    = c[0];
        f.payload     = d[PayloadWidth-1:0];
        chk.expect_flit(f);
      end else if (op == "A" || op == "R") begin
        n = $fscanf(fd, "%h %h %h", a, b, c);
        if (op == "A") begin
          {aw_id_i, aw_addr_i, aw_len_i} = {a[3:0], b[31:0], c[7:0]};
          aw_valid_i = 1'b1;
          handshake(0, "AW");
          aw_valid_i = 1'b0;
        end else begin
          {ar_id_i, ar_addr_i, ar_len_i} = {a[3:0], b[31:0], c[7:0]};
          ar_valid_i = 1'b1;
          handshake(2, "AR");
          ar_valid_i = 1'b0;
        end
      end else if (op == "W") begin
        n = $fscanf(fd, "%h %h", a, b);
        w_data_i  = a[31:0];
        w_last_i  = b[0];
        w_valid_i = 1'b1;
        handshake(1, "W");
        w_valid_i = 1'b0;
      end else if (op == "B" || op == "D") begin
        f = '0;
        f.hdr.dst_id = TileId;
        f.hdr.last   = 1'b1;
        if (op == "B") begin
          n = $fscanf(fd, "%h %h", a, b);
          f.hdr.axi_ch    = AxiB;
          f.payload[5:0]  = {a[3:0], b[1:0]};
          chk.expect_b({a[3:0], b[1:0]});
        end else begin
          n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          f.hdr.axi_ch    = AxiR;
          f.payload[38:0] = {a[3:0], b[31:0], c[1:0], d[0]};
          chk.expect_r({a[3:0], b[31:0], c[1:0], d[0]});
        end
        rsp_flit_i  = f;
        rsp_valid_i = 1'b1;
        handshake(3, "response link");
        rsp_valid_i = 1'b0;
      end else if (op == "E") begin
        wait_drained();
        if (!aborted) chk.end_test();
      end else begin
        chk.note_failure($sformatf("unknown stimulus operation %s", op));
        aborted = 1'b1;
      end
    end
    if (aborted) chk.end_test();
    if (fd != 0) $fclose(fd);
    chk.report();
    if (chk.error_total == 0 && !aborted) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
